// ==== project.f ====
+incdir+src
src/looper_syst_pkg.sv
src/looper_grid_pkg.sv
src/grid_stepper.sv
src/block_dispatch.sv
src/channel_reg.sv
src/accum_block_looper.sv
testbench/tb_accum_block_looper.sv

// ==== Makefile ====
TOP = tb_accum_block_looper
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP)

run: build
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "Test FAILED" $(LOG)
	grep -q "Test OK" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module accum_block_looper

clean:
	rm -rf obj_dir $(LOG)

// ==== testbench/tb_accum_block_looper.sv ====
/*
 * Testbench for the accumulation block looper
 * Random loop commands and consumer back-pressure, checked against a model
 */
`default_nettype none
`include "looper_config.svh"

module tb_accum_block_looper;
	import looper_grid_pkg::*;
	import looper_syst_pkg::*;

	localparam int N_CMDS = 12;

	logic i_clk, i_reset, i_src_rdy, o_src_ack, o_blkdone;
	ofs_vec_t i_bofs, i_agrid_step, i_agrid_end, i_aboundary;
	syst_gsize_t i_i0_systolic_gsize, i_i1_systolic_gsize;
	syst_idx_t i_i0_systolic_idx, i_i1_systolic_idx;
	icfg_ids_t i_i0_id_begs, i_i0_id_ends, i_i1_id_begs, i_i1_id_ends;
	ocfg_ids_t i_o_id_begs, i_o_id_ends;
	inst_ids_t i_inst_id_begs, i_inst_id_ends;
	logic o_i0_rdy, i_i0_ack, o_i1_rdy, i_i1_ack, o_o_rdy, i_o_ack, o_alu_rdy, i_alu_ack;
	ofs_vec_t o_i0_bofs, o_i0_aofs_beg, o_i0_aofs_end;
	ofs_vec_t o_i1_bofs, o_i1_aofs_beg, o_i1_aofs_end;
	ofs_vec_t o_o_bofs, o_o_aofs_beg, o_o_aofs_end;
	ofs_vec_t o_alu_bofs, o_alu_aofs_beg, o_alu_aofs_end;
	icfg_id_t o_i0_beg, o_i0_end, o_i1_beg, o_i1_end;
	ocfg_id_t o_o_beg, o_o_end;
	syst_type_t o_i0_syst_type, o_i1_syst_type;

	// Channel order i0, i1, o, alu
	string chan_name [4] = '{"i0", "i1", "o", "alu"};
	logic [127:0] exp_q [4][$];
	logic [127:0] seen [4];
	logic [127:0] hold_pay [4];
	logic [3:0] seen_rdy, seen_ack;
	logic [3:0] hold_rdy = '0;
	logic [3:0] hold_ack = '0;
	logic [31:0] rng_state = 32'd50;
	logic [31:0] stall_bits = '0;
	int done_pending = 0;
	int done_seen = 0;
	logic last_alu_skip = 1'b0;
	time deadline = 2000;

	accum_block_looper dut_i (.*);

	assign seen[0] = 128'({o_i0_bofs, o_i0_aofs_beg, o_i0_aofs_end, o_i0_beg, o_i0_end,
		o_i0_syst_type});
	assign seen[1] = 128'({o_i1_bofs, o_i1_aofs_beg, o_i1_aofs_end, o_i1_beg, o_i1_end,
		o_i1_syst_type});
	assign seen[2] = 128'({o_o_bofs, o_o_aofs_beg, o_o_aofs_end, o_o_beg, o_o_end});
	assign seen[3] = 128'({o_alu_bofs, o_alu_aofs_beg, o_alu_aofs_end});
	assign seen_rdy = {o_alu_rdy, o_o_rdy, o_i1_rdy, o_i0_rdy};
	assign seen_ack = {i_alu_ack, i_o_ack, i_i1_ack, i_i0_ack};

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Position of the count against the index and its mirror
	function automatic syst_type_t expect_syst_type(input int cnt, input int gsize,
		input int idx);
		int mirror;
		mirror = 2 * gsize - 1 - idx;
		if (cnt == idx || cnt == mirror)
			return SYST_EDGE;
		if (cnt < idx || cnt > mirror)
			return SYST_OUTER;
		return SYST_INNER;
	endfunction

	task automatic show_mismatch(input string name, input logic [127:0] exp,
		input logic [127:0] got);
		$display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp, got);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic abort_run(input string text);
		$display("ERROR at %0t: %s", $time, text);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [127:0] exp,
		input logic [127:0] got);
		assert (got == exp) else show_mismatch(name, exp, got);
	endtask

	// ========================================================
	// Command generation and reference model
	// ========================================================
	task automatic load_command(input int k);
		int n [2];
		int pos [2];
		int g [2];
		int ix [2];
		int cnt [2];
		int lb, le, a, b;
		logic run_b, run_e;
		ofs_vec_t beg, fin;
		in_blk_t ei;
		out_blk_t eo;
		alu_blk_t ea;
		i_bofs = ofs_vec_t'(next_rand());
		for (int d = 0; d < `LOOPER_VDIM; d++) begin
			i_agrid_step[d] = ofs_t'(1 + next_rand() % 3);
			i_agrid_end[d] = ofs_t'(1 + next_rand() % 8);
			i_aboundary[d] = ofs_t'(int'(i_agrid_end[d]) - 1 + int'(next_rand() % 3));
			g[d] = 1 + int'(next_rand() % 4);
			ix[d] = int'(next_rand() % 32'(g[d]));
			cnt[d] = 0;
		end
		// First loop has steps that do not divide the grid end
		if (k == 0) begin
			i_agrid_step = {16'd2, 16'd3};
			i_agrid_end = {16'd5, 16'd7};
			i_aboundary = {16'd4, 16'd7};
		end
		for (int l = 0; l <= `LOOPER_VDIM; l++) begin
			i_i0_id_begs[l] = icfg_id_t'(next_rand() % 4);
			i_i0_id_ends[l] = icfg_id_t'(32'(i_i0_id_begs[l]) + next_rand() % 3);
			i_i1_id_begs[l] = icfg_id_t'(next_rand() % 4);
			i_i1_id_ends[l] = icfg_id_t'(32'(i_i1_id_begs[l]) + next_rand() % 3);
			i_o_id_begs[l] = ocfg_id_t'(next_rand() % 3);
			i_o_id_ends[l] = ocfg_id_t'(32'(i_o_id_begs[l]) + next_rand() % 2);
			i_inst_id_begs[l] = inst_id_t'(next_rand() % 8);
			i_inst_id_ends[l] = inst_id_t'(32'(i_inst_id_begs[l]) + next_rand() % 3);
		end
		i_i0_systolic_gsize = syst_gsize_t'(g[0]);
		i_i0_systolic_idx = syst_idx_t'(ix[0]);
		i_i1_systolic_gsize = syst_gsize_t'(g[1]);
		i_i1_systolic_idx = syst_idx_t'(ix[1]);
		for (int d = 0; d < `LOOPER_VDIM; d++)
			n[d] = (int'(i_agrid_end[d]) + int'(i_agrid_step[d]) - 1) / int'(i_agrid_step[d]);
		// Second loop ends on a block with no ALU work
		if (k == 1) begin
			lb = (n[0] == 1) ? ((n[1] == 1) ? 2 : 1) : 0;
			i_inst_id_begs[lb] = i_inst_id_ends[`LOOPER_VDIM];
		end
		for (int p1 = 0; p1 < n[1]; p1++) begin
			for (int p0 = 0; p0 < n[0]; p0++) begin
				pos[0] = p0;
				pos[1] = p1;
				lb = 0;
				le = 0;
				run_b = 1'b1;
				run_e = 1'b1;
				for (int d = 0; d < `LOOPER_VDIM; d++) begin
					a = pos[d] * int'(i_agrid_step[d]);
					b = a + int'(i_agrid_step[d]);
					if (b > int'(i_aboundary[d]))
						b = int'(i_aboundary[d]);
					beg[d] = ofs_t'(a);
					fin[d] = ofs_t'(b);
					run_b = run_b && pos[d] == 0;
					run_e = run_e && pos[d] == n[d] - 1;
					lb = lb + int'(run_b);
					le = le + int'(run_e);
				end
				ei = '{bofs: i_bofs, aofs_beg: beg, aofs_end: fin, id_beg: i_i0_id_begs[lb],
					id_end: i_i0_id_ends[le], syst_type: expect_syst_type(cnt[0], g[0], ix[0])};
				if (ei.id_beg != ei.id_end)
					exp_q[0].push_back(128'(ei));
				ei = '{bofs: i_bofs, aofs_beg: beg, aofs_end: fin, id_beg: i_i1_id_begs[lb],
					id_end: i_i1_id_ends[le], syst_type: expect_syst_type(cnt[1], g[1], ix[1])};
				if (ei.id_beg != ei.id_end)
					exp_q[1].push_back(128'(ei));
				eo = '{bofs: i_bofs, aofs_beg: beg, aofs_end: fin, id_beg: i_o_id_begs[lb],
					id_end: i_o_id_ends[le]};
				if (eo.id_beg != eo.id_end)
					exp_q[2].push_back(128'(eo));
				ea = '{bofs: i_bofs, aofs_beg: beg, aofs_end: fin};
				last_alu_skip = i_inst_id_begs[lb] == i_inst_id_ends[le];
				if (!last_alu_skip)
					exp_q[3].push_back(128'(ea));
				for (int c = 0; c < 2; c++)
					cnt[c] = (cnt[c] == 2 * g[c] - 1) ? 0 : cnt[c] + 1;
			end
		end
		done_pending = done_pending + 1;
		deadline = $time + 20 * (40 * n[0] * n[1] + 40);
	endtask

	// ========================================================
	// Clock, back-pressure and watchdog
	// ========================================================
	initial begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	always @(negedge i_clk)
		stall_bits = next_rand();

	// Each consumer takes an offered entry three times in four
	always @(posedge i_clk) begin
		#2;
		i_i0_ack = o_i0_rdy && stall_bits[1:0] != 2'b00;
		i_i1_ack = o_i1_rdy && stall_bits[3:2] != 2'b00;
		i_o_ack = o_o_rdy && stall_bits[5:4] != 2'b00;
		i_alu_ack = o_alu_rdy && stall_bits[7:6] != 2'b00;
	end

	initial begin
		while ($time <= deadline)
			@(posedge i_clk);
		$display("Run timed out at %0t with blocks still outstanding", $time);
		$display("Test FAILED");
		$fatal(1);
	end

	// ========================================================
	// Output checks
	// ========================================================
	always @(negedge i_clk) begin
		if (!i_reset) begin
			assert (!o_src_ack || i_src_rdy) else abort_run("o_src_ack came with no command");
			if (o_blkdone) begin
				check_value("o_blkdone pending loops", 1, 128'(done_pending));
				if (last_alu_skip)
					assert (exp_q[3].size() <= 1)
					else abort_run("o_blkdone came before the ALU entries of the loop");
				else
					check_value("ALU entries open at o_blkdone", 1, 128'(exp_q[3].size()));
				done_pending = done_pending - 1;
				done_seen = done_seen + 1;
			end
			// The last block is taken no earlier than its ALU entry
			if (o_src_ack) begin
				assert (done_pending == 0)
				else abort_run("o_src_ack came before the o_blkdone of its loop");
			end
			for (int c = 0; c < 4; c++) begin
				if (hold_rdy[c] && !hold_ack[c]) begin
					check_value({chan_name[c], " rdy while stalled"}, 1, 128'(seen_rdy[c]));
					check_value({chan_name[c], " payload while stalled"}, hold_pay[c], seen[c]);
				end
				if (seen_rdy[c] && seen_ack[c]) begin
					assert (exp_q[c].size() != 0)
					else abort_run({"Unexpected block on the ", chan_name[c], " channel"});
					check_value({chan_name[c], " payload"}, exp_q[c].pop_front(), seen[c]);
				end
				hold_pay[c] = seen[c];
			end
			hold_rdy = seen_rdy;
			hold_ack = seen_ack;
		end
	end

	// ========================================================
	// Main sequence
	// ========================================================
	initial begin
		i_reset = 1'b1;
		i_src_rdy = 1'b0;
		i_bofs = '0;
		i_agrid_step = '0;
		i_agrid_end = '0;
		i_aboundary = '0;
		i_i0_systolic_gsize = '0;
		i_i0_systolic_idx = '0;
		i_i1_systolic_gsize = '0;
		i_i1_systolic_idx = '0;
		i_i0_id_begs = '0;
		i_i0_id_ends = '0;
		i_i1_id_begs = '0;
		i_i1_id_ends = '0;
		i_o_id_begs = '0;
		i_o_id_ends = '0;
		i_inst_id_begs = '0;
		i_inst_id_ends = '0;
		i_i0_ack = 1'b0;
		i_i1_ack = 1'b0;
		i_o_ack = 1'b0;
		i_alu_ack = 1'b0;
		repeat (4) @(posedge i_clk);
		#2;
		i_reset = 1'b0;
		@(negedge i_clk);
		check_value("rdy, o_src_ack and o_blkdone after reset", '0,
			128'({seen_rdy, o_src_ack, o_blkdone}));
		for (int c = 0; c < 4; c++)
			check_value({chan_name[c], " payload after reset"}, '0, seen[c]);
		for (int k = 0; k < N_CMDS; k++) begin
			@(posedge i_clk);
			#2;
			load_command(k);
			i_src_rdy = 1'b1;
			do
				@(negedge i_clk);
			while (!o_src_ack);
			@(posedge i_clk);
			#2;
			i_src_rdy = 1'b0;
			// Drain every channel before the next command
			while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size() != 0
				|| done_pending != 0)
				@(posedge i_clk);
		end
		if (done_seen == N_CMDS) begin
			$display("Test OK");
			$finish;
		end else begin
			show_mismatch("o_blkdone pulse count", N_CMDS, 128'(done_seen));
		end
	end

endmodule

`default_nettype wire

// ==== src/accum_block_looper.sv ====
/*
 * Accumulation block looper
 * Walks the accumulation blocks of one loop command and hands each block
 * to the input 0, input 1, output and ALU consumers
 */
`default_nettype none

module accum_block_looper (
	input  wire logic                         i_clk,
	input  wire logic                         i_reset,
	input  wire logic                         i_src_rdy,
	output logic                              o_src_ack,
	input  wire looper_grid_pkg::ofs_vec_t    i_bofs,
	input  wire looper_syst_pkg::syst_gsize_t i_i0_systolic_gsize,
	input  wire looper_syst_pkg::syst_idx_t   i_i0_systolic_idx,
	input  wire looper_syst_pkg::syst_gsize_t i_i1_systolic_gsize,
	input  wire looper_syst_pkg::syst_idx_t   i_i1_systolic_idx,
	input  wire looper_grid_pkg::ofs_vec_t    i_agrid_step,
	input  wire looper_grid_pkg::ofs_vec_t    i_agrid_end,
	input  wire looper_grid_pkg::ofs_vec_t    i_aboundary,
	input  wire looper_grid_pkg::icfg_ids_t   i_i0_id_begs,
	input  wire looper_grid_pkg::icfg_ids_t   i_i0_id_ends,
	input  wire looper_grid_pkg::icfg_ids_t   i_i1_id_begs,
	input  wire looper_grid_pkg::icfg_ids_t   i_i1_id_ends,
	input  wire looper_grid_pkg::ocfg_ids_t   i_o_id_begs,
	input  wire looper_grid_pkg::ocfg_ids_t   i_o_id_ends,
	input  wire looper_grid_pkg::inst_ids_t   i_inst_id_begs,
	input  wire looper_grid_pkg::inst_ids_t   i_inst_id_ends,
	output logic                              o_i0_rdy,
	input  wire logic                         i_i0_ack,
	output looper_grid_pkg::ofs_vec_t         o_i0_bofs,
	output looper_grid_pkg::ofs_vec_t         o_i0_aofs_beg,
	output looper_grid_pkg::ofs_vec_t         o_i0_aofs_end,
	output looper_grid_pkg::icfg_id_t         o_i0_beg,
	output looper_grid_pkg::icfg_id_t         o_i0_end,
	output looper_syst_pkg::syst_type_t       o_i0_syst_type,
	output logic                              o_i1_rdy,
	input  wire logic                         i_i1_ack,
	output looper_grid_pkg::ofs_vec_t         o_i1_bofs,
	output looper_grid_pkg::ofs_vec_t         o_i1_aofs_beg,
	output looper_grid_pkg::ofs_vec_t         o_i1_aofs_end,
	output looper_grid_pkg::icfg_id_t         o_i1_beg,
	output looper_grid_pkg::icfg_id_t         o_i1_end,
	output looper_syst_pkg::syst_type_t       o_i1_syst_type,
	output logic                              o_o_rdy,
	input  wire logic                         i_o_ack,
	output looper_grid_pkg::ofs_vec_t         o_o_bofs,
	output looper_grid_pkg::ofs_vec_t         o_o_aofs_beg,
	output looper_grid_pkg::ofs_vec_t         o_o_aofs_end,
	output looper_grid_pkg::ocfg_id_t         o_o_beg,
	output looper_grid_pkg::ocfg_id_t         o_o_end,
	output logic                              o_alu_rdy,
	input  wire logic                         i_alu_ack,
	output looper_grid_pkg::ofs_vec_t         o_alu_bofs,
	output looper_grid_pkg::ofs_vec_t         o_alu_aofs_beg,
	output looper_grid_pkg::ofs_vec_t         o_alu_aofs_end,
	output logic                              o_blkdone
);
	import looper_grid_pkg::*;

	logic blk_rdy, blk_ack, blk_last, loop_init;
	ofs_vec_t blk_aofs_beg;
	level_t blk_level_beg, blk_level_end;
	logic i0_rdy, i0_ack, i1_rdy, i1_ack, o_rdy, o_ack, alu_rdy, alu_ack;
	in_blk_t i0_blk, i0_q, i1_blk, i1_q;
	out_blk_t o_blk, o_q;
	alu_blk_t alu_blk, alu_q;

	// ========================================================
	// Stepper and dispatcher
	// ========================================================
	grid_stepper u_stepper (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_src_rdy(i_src_rdy), .o_src_ack(o_src_ack),
		.i_agrid_step(i_agrid_step), .i_agrid_end(i_agrid_end),
		.o_blk_rdy(blk_rdy), .i_blk_ack(blk_ack),
		.o_blk_aofs_beg(blk_aofs_beg),
		.o_blk_level_beg(blk_level_beg), .o_blk_level_end(blk_level_end),
		.o_blk_last(blk_last), .o_loop_init(loop_init)
	);

	block_dispatch u_dispatch (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_bofs(i_bofs), .i_aboundary(i_aboundary), .i_agrid_step(i_agrid_step),
		.i_i0_id_begs(i_i0_id_begs), .i_i0_id_ends(i_i0_id_ends),
		.i_i1_id_begs(i_i1_id_begs), .i_i1_id_ends(i_i1_id_ends),
		.i_o_id_begs(i_o_id_begs), .i_o_id_ends(i_o_id_ends),
		.i_inst_id_begs(i_inst_id_begs), .i_inst_id_ends(i_inst_id_ends),
		.i_i0_systolic_gsize(i_i0_systolic_gsize), .i_i0_systolic_idx(i_i0_systolic_idx),
		.i_i1_systolic_gsize(i_i1_systolic_gsize), .i_i1_systolic_idx(i_i1_systolic_idx),
		.i_blk_rdy(blk_rdy), .o_blk_ack(blk_ack), .i_blk_aofs_beg(blk_aofs_beg),
		.i_blk_level_beg(blk_level_beg), .i_blk_level_end(blk_level_end),
		.i_blk_last(blk_last), .i_loop_init(loop_init),
		.o_i0_rdy(i0_rdy), .i_i0_ack(i0_ack), .o_i0_blk(i0_blk),
		.o_i1_rdy(i1_rdy), .i_i1_ack(i1_ack), .o_i1_blk(i1_blk),
		.o_o_rdy(o_rdy), .i_o_ack(o_ack), .o_o_blk(o_blk),
		.o_alu_rdy(alu_rdy), .i_alu_ack(alu_ack), .o_alu_blk(alu_blk),
		.o_blkdone(o_blkdone)
	);

	// ========================================================
	// Output registers, one per consumer
	// ========================================================
	channel_reg #(.PAYLOAD_T(in_blk_t)) u_i0_reg (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_rdy(i0_rdy), .o_ack(i0_ack), .i_payload(i0_blk),
		.o_rdy(o_i0_rdy), .i_ack(i_i0_ack), .o_payload(i0_q)
	);

	channel_reg #(.PAYLOAD_T(in_blk_t)) u_i1_reg (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_rdy(i1_rdy), .o_ack(i1_ack), .i_payload(i1_blk),
		.o_rdy(o_i1_rdy), .i_ack(i_i1_ack), .o_payload(i1_q)
	);

	channel_reg #(.PAYLOAD_T(out_blk_t)) u_o_reg (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_rdy(o_rdy), .o_ack(o_ack), .i_payload(o_blk),
		.o_rdy(o_o_rdy), .i_ack(i_o_ack), .o_payload(o_q)
	);

	channel_reg #(.PAYLOAD_T(alu_blk_t)) u_alu_reg (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_rdy(alu_rdy), .o_ack(alu_ack), .i_payload(alu_blk),
		.o_rdy(o_alu_rdy), .i_ack(i_alu_ack), .o_payload(alu_q)
	);

	// Split the registered payloads into the loose output fields
	assign o_i0_bofs = i0_q.bofs;
	assign o_i0_aofs_beg = i0_q.aofs_beg;
	assign o_i0_aofs_end = i0_q.aofs_end;
	assign o_i0_beg = i0_q.id_beg;
	assign o_i0_end = i0_q.id_end;
	assign o_i0_syst_type = i0_q.syst_type;
	assign o_i1_bofs = i1_q.bofs;
	assign o_i1_aofs_beg = i1_q.aofs_beg;
	assign o_i1_aofs_end = i1_q.aofs_end;
	assign o_i1_beg = i1_q.id_beg;
	assign o_i1_end = i1_q.id_end;
	assign o_i1_syst_type = i1_q.syst_type;
	assign o_o_bofs = o_q.bofs;
	assign o_o_aofs_beg = o_q.aofs_beg;
	assign o_o_aofs_end = o_q.aofs_end;
	assign o_o_beg = o_q.id_beg;
	assign o_o_end = o_q.id_end;
	assign o_alu_bofs = alu_q.bofs;
	assign o_alu_aofs_beg = alu_q.aofs_beg;
	assign o_alu_aofs_end = alu_q.aofs_end;

endmodule

`default_nettype wire

// ==== src/channel_reg.sv ====
/*
 * Channel register
 * One-entry rdy/ack forwarding stage for any payload type
 */
`default_nettype none

module channel_reg #(
	parameter type PAYLOAD_T = logic
) (
	input  wire logic     i_clk,
	input  wire logic     i_reset,
	input  wire logic     i_rdy,
	output logic          o_ack,
	input  wire PAYLOAD_T i_payload,
	output logic          o_rdy,
	input  wire logic     i_ack,
	output PAYLOAD_T      o_payload
);

	logic full_r;

	// Takes a new entry only while empty
	assign o_ack = i_rdy && !full_r;
	assign o_rdy = full_r;

	always_ff @(posedge i_clk) begin
		if (i_reset)
			full_r <= 1'b0;
		else if (o_ack)
			full_r <= 1'b1;
		else if (i_ack)
			full_r <= 1'b0;
	end

	always_ff @(posedge i_clk) begin
		if (i_reset)
			o_payload <= '0;
		else if (o_ack)
			o_payload <= i_payload;
	end

	a_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		o_rdy && !i_ack |=> o_rdy && $stable(o_payload));

endmodule

`default_nettype wire

// ==== src/block_dispatch.sv ====
/*
 * Block dispatcher
 * Clamps each block to the boundary, picks the id ranges by loop level,
 * classifies the systolic position and broadcasts to four channels
 */
`default_nettype none
`include "looper_config.svh"

module block_dispatch (
	input  wire logic                         i_clk,
	input  wire logic                         i_reset,
	input  wire looper_grid_pkg::ofs_vec_t    i_bofs,
	input  wire looper_grid_pkg::ofs_vec_t    i_aboundary,
	input  wire looper_grid_pkg::ofs_vec_t    i_agrid_step,
	input  wire looper_grid_pkg::icfg_ids_t   i_i0_id_begs,
	input  wire looper_grid_pkg::icfg_ids_t   i_i0_id_ends,
	input  wire looper_grid_pkg::icfg_ids_t   i_i1_id_begs,
	input  wire looper_grid_pkg::icfg_ids_t   i_i1_id_ends,
	input  wire looper_grid_pkg::ocfg_ids_t   i_o_id_begs,
	input  wire looper_grid_pkg::ocfg_ids_t   i_o_id_ends,
	input  wire looper_grid_pkg::inst_ids_t   i_inst_id_begs,
	input  wire looper_grid_pkg::inst_ids_t   i_inst_id_ends,
	input  wire looper_syst_pkg::syst_gsize_t i_i0_systolic_gsize,
	input  wire looper_syst_pkg::syst_idx_t   i_i0_systolic_idx,
	input  wire looper_syst_pkg::syst_gsize_t i_i1_systolic_gsize,
	input  wire looper_syst_pkg::syst_idx_t   i_i1_systolic_idx,
	input  wire logic                         i_blk_rdy,
	output logic                              o_blk_ack,
	input  wire looper_grid_pkg::ofs_vec_t    i_blk_aofs_beg,
	input  wire looper_grid_pkg::level_t      i_blk_level_beg,
	input  wire looper_grid_pkg::level_t      i_blk_level_end,
	input  wire logic                         i_blk_last,
	input  wire logic                         i_loop_init,
	output logic                              o_i0_rdy,
	input  wire logic                         i_i0_ack,
	output looper_grid_pkg::in_blk_t          o_i0_blk,
	output logic                              o_i1_rdy,
	input  wire logic                         i_i1_ack,
	output looper_grid_pkg::in_blk_t          o_i1_blk,
	output logic                              o_o_rdy,
	input  wire logic                         i_o_ack,
	output looper_grid_pkg::out_blk_t         o_o_blk,
	output logic                              o_alu_rdy,
	input  wire logic                         i_alu_ack,
	output looper_grid_pkg::alu_blk_t         o_alu_blk,
	output logic                              o_blkdone
);
	import looper_grid_pkg::*;
	import looper_syst_pkg::*;

	// Channel order in the vectors below is i0, i1, o, alu
	logic [3:0] done_r;
	logic [3:0] skip;
	logic [3:0] ch_rdy;
	logic [3:0] ch_ack;
	ofs_vec_t aofs_end;
	logic [`LOOPER_WORK_BW:0] end_raw [`LOOPER_VDIM];
	icfg_id_t i0_beg, i0_end, i1_beg, i1_end;
	ocfg_id_t o_beg, o_end;
	inst_id_t alu_beg, alu_end;
	syst_cnt_t cnt_r [2];
	syst_cnt_t cnt_cur [2];
	syst_cnt_t cnt_nxt [2];
	syst_cnt_t bound [2];
	syst_cnt_t idx [2];
	syst_type_t styp [2];

	function automatic syst_type_t classify(input syst_cnt_t cnt, input syst_cnt_t pos,
		input syst_cnt_t lim);
		syst_cnt_t mirror;
		mirror = lim - pos;
		if (cnt == pos || cnt == mirror)
			return SYST_EDGE;
		else if (cnt < pos || cnt > mirror)
			return SYST_OUTER;
		else
			return SYST_INNER;
	endfunction

	// ========================================================
	// Block end clamp and id selection
	// ========================================================
	always_comb begin
		for (int d = 0; d < `LOOPER_VDIM; d++) begin
			end_raw[d] = {1'b0, i_blk_aofs_beg[d]} + {1'b0, i_agrid_step[d]};
			aofs_end[d] = end_raw[d] > {1'b0, i_aboundary[d]} ?
				i_aboundary[d] : end_raw[d][`LOOPER_WORK_BW-1:0];
		end
	end

	assign i0_beg = i_i0_id_begs[i_blk_level_beg];
	assign i0_end = i_i0_id_ends[i_blk_level_end];
	assign i1_beg = i_i1_id_begs[i_blk_level_beg];
	assign i1_end = i_i1_id_ends[i_blk_level_end];
	assign o_beg = i_o_id_begs[i_blk_level_beg];
	assign o_end = i_o_id_ends[i_blk_level_end];
	assign alu_beg = i_inst_id_begs[i_blk_level_beg];
	assign alu_end = i_inst_id_ends[i_blk_level_end];

	// ========================================================
	// Systolic counters, one step per block
	// ========================================================
	assign bound[0] = syst_cnt_t'({i_i0_systolic_gsize, 1'b0} - 1'b1);
	assign bound[1] = syst_cnt_t'({i_i1_systolic_gsize, 1'b0} - 1'b1);
	assign idx[0] = syst_cnt_t'(i_i0_systolic_idx);
	assign idx[1] = syst_cnt_t'(i_i1_systolic_idx);

	always_comb begin
		for (int c = 0; c < 2; c++) begin
			// First block of a loop counts from zero
			cnt_cur[c] = i_loop_init ? '0 : cnt_r[c];
			cnt_nxt[c] = cnt_cur[c] == bound[c] ? '0 : cnt_cur[c] + 1'b1;
			styp[c] = classify(cnt_cur[c], idx[c], bound[c]);
		end
	end

	always_ff @(posedge i_clk) begin
		for (int c = 0; c < 2; c++) begin
			if (i_reset)
				cnt_r[c] <= '0;
			else if (o_blk_ack)
				cnt_r[c] <= cnt_nxt[c];
			else if (i_loop_init)
				cnt_r[c] <= '0;
		end
	end

	// ========================================================
	// Broadcast with per-channel done bits
	// ========================================================
	assign skip = {alu_beg == alu_end, o_beg == o_end, i1_beg == i1_end, i0_beg == i0_end};
	assign ch_rdy = {4{i_blk_rdy}} & ~done_r & ~skip;
	assign ch_ack = {i_alu_ack, i_o_ack, i_i1_ack, i_i0_ack};
	assign {o_alu_rdy, o_o_rdy, o_i1_rdy, o_i0_rdy} = ch_rdy;
	assign o_blk_ack = i_blk_rdy && &(done_r | skip | ch_ack);
	assign o_blkdone = i_blk_last && (i_alu_ack || (skip[3] && o_blk_ack));

	always_ff @(posedge i_clk) begin
		if (i_reset || o_blk_ack)
			done_r <= '0;
		else
			done_r <= done_r | ch_ack;
	end

	assign o_i0_blk = '{bofs: i_bofs, aofs_beg: i_blk_aofs_beg, aofs_end: aofs_end,
		id_beg: i0_beg, id_end: i0_end, syst_type: styp[0]};
	assign o_i1_blk = '{bofs: i_bofs, aofs_beg: i_blk_aofs_beg, aofs_end: aofs_end,
		id_beg: i1_beg, id_end: i1_end, syst_type: styp[1]};
	assign o_o_blk = '{bofs: i_bofs, aofs_beg: i_blk_aofs_beg, aofs_end: aofs_end,
		id_beg: o_beg, id_end: o_end};
	assign o_alu_blk = '{bofs: i_bofs, aofs_beg: i_blk_aofs_beg, aofs_end: aofs_end};

	a_syst_valid: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_i0_rdy -> o_i0_blk.syst_type != SYST_NONE) &&
		(o_i1_rdy -> o_i1_blk.syst_type != SYST_NONE));

	// Channel registers only take a block that is offered
	a_ack_in_rdy: assert property (@(posedge i_clk) disable iff (i_reset)
		(ch_ack & ~ch_rdy) == '0);

endmodule

`default_nettype wire

// ==== src/grid_stepper.sv ====
/*
 * Grid stepper
 * Takes a loop command and walks the block offsets in row-major order,
 * dimension 0 innermost, reporting the loop levels of every block
 */
`default_nettype none
`include "looper_config.svh"

module grid_stepper (
	input  wire logic                      i_clk,
	input  wire logic                      i_reset,
	input  wire logic                      i_src_rdy,
	output logic                           o_src_ack,
	input  wire looper_grid_pkg::ofs_vec_t i_agrid_step,
	input  wire looper_grid_pkg::ofs_vec_t i_agrid_end,
	output logic                           o_blk_rdy,
	input  wire logic                      i_blk_ack,
	output looper_grid_pkg::ofs_vec_t      o_blk_aofs_beg,
	output looper_grid_pkg::level_t        o_blk_level_beg,
	output looper_grid_pkg::level_t        o_blk_level_end,
	output logic                           o_blk_last,
	output logic                           o_loop_init
);
	import looper_grid_pkg::*;

	logic busy_r;
	logic init_r;
	ofs_vec_t ofs_r;
	ofs_vec_t ofs_nxt;
	logic [`LOOPER_WORK_BW:0] ofs_sum [`LOOPER_VDIM];
	logic [`LOOPER_VDIM-1:0] at_zero;
	logic [`LOOPER_VDIM-1:0] at_last;

	// ========================================================
	// Position flags and loop levels
	// ========================================================
	always_comb begin
		for (int d = 0; d < `LOOPER_VDIM; d++) begin
			ofs_sum[d] = {1'b0, ofs_r[d]} + {1'b0, i_agrid_step[d]};
			at_zero[d] = ofs_r[d] == '0;
			at_last[d] = ofs_sum[d] >= {1'b0, i_agrid_end[d]};
		end
	end

	// Count the innermost dimensions that sit at zero or at their last step
	always_comb begin
		logic run_z;
		logic run_l;
		run_z = 1'b1;
		run_l = 1'b1;
		o_blk_level_beg = '0;
		o_blk_level_end = '0;
		for (int d = 0; d < `LOOPER_VDIM; d++) begin
			run_z = run_z && at_zero[d];
			run_l = run_l && at_last[d];
			if (run_z)
				o_blk_level_beg = o_blk_level_beg + 1'b1;
			if (run_l)
				o_blk_level_end = o_blk_level_end + 1'b1;
		end
	end

	// Next offsets, carrying from dimension 0 outwards
	always_comb begin
		logic carry;
		carry = 1'b1;
		for (int d = 0; d < `LOOPER_VDIM; d++) begin
			ofs_nxt[d] = ofs_r[d];
			if (carry)
				ofs_nxt[d] = at_last[d] ? '0 : ofs_sum[d][`LOOPER_WORK_BW-1:0];
			carry = carry && at_last[d];
		end
	end

	assign o_blk_last = &at_last;
	assign o_blk_rdy = busy_r;
	assign o_blk_aofs_beg = ofs_r;
	assign o_loop_init = init_r;
	assign o_src_ack = busy_r && i_blk_ack && o_blk_last;

	// ========================================================
	// Loop state
	// ========================================================
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			busy_r <= 1'b0;
			init_r <= 1'b0;
			ofs_r <= '0;
		end else begin
			init_r <= !busy_r && i_src_rdy;
			if (!busy_r && i_src_rdy) begin
				busy_r <= 1'b1;
				ofs_r <= '0;
			end else if (busy_r && i_blk_ack) begin
				ofs_r <= ofs_nxt;
				if (o_blk_last)
					busy_r <= 1'b0;
			end
		end
	end

	// A block holds its offsets until the dispatcher takes it
	a_blk_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		o_blk_rdy && !i_blk_ack |=> o_blk_rdy && $stable(o_blk_aofs_beg));

endmodule

`default_nettype wire

// ==== src/looper_grid_pkg.sv ====
/*
 * Grid geometry and channel payload types of the accumulation block looper
 */
`default_nettype none
`include "looper_config.svh"

package looper_grid_pkg;

	typedef logic [`LOOPER_WORK_BW-1:0] ofs_t;
	typedef ofs_t [`LOOPER_VDIM-1:0] ofs_vec_t;

	// Loop level, 0 up to VDIM
	typedef logic [$clog2(`LOOPER_VDIM+1)-1:0] level_t;

	typedef logic [$clog2(`LOOPER_N_ICFG+1)-1:0] icfg_id_t;
	typedef logic [$clog2(`LOOPER_N_OCFG+1)-1:0] ocfg_id_t;
	typedef logic [$clog2(`LOOPER_N_INST+1)-1:0] inst_id_t;

	// One id per loop level
	typedef icfg_id_t [`LOOPER_VDIM:0] icfg_ids_t;
	typedef ocfg_id_t [`LOOPER_VDIM:0] ocfg_ids_t;
	typedef inst_id_t [`LOOPER_VDIM:0] inst_ids_t;

	typedef struct packed {
		ofs_vec_t bofs;
		ofs_vec_t aofs_beg;
		ofs_vec_t aofs_end;
		icfg_id_t id_beg;
		icfg_id_t id_end;
		looper_syst_pkg::syst_type_t syst_type;
	} in_blk_t;

	typedef struct packed {
		ofs_vec_t bofs;
		ofs_vec_t aofs_beg;
		ofs_vec_t aofs_end;
		ocfg_id_t id_beg;
		ocfg_id_t id_end;
	} out_blk_t;

	typedef struct packed {
		ofs_vec_t bofs;
		ofs_vec_t aofs_beg;
		ofs_vec_t aofs_end;
	} alu_blk_t;

endpackage

`default_nettype wire

// ==== src/looper_syst_pkg.sv ====
/*
 * Systolic definitions for the accumulation block looper
 * Group size, index, counter and the position type sent on input channels
 */
`default_nettype none
`include "looper_config.svh"

package looper_syst_pkg;

	typedef logic [$clog2(`LOOPER_N_TAU+1)-1:0] syst_gsize_t;
	typedef logic [$clog2(`LOOPER_N_TAU)-1:0] syst_idx_t;

	// Runs from 0 up to twice the group size minus one
	typedef logic [$clog2(`LOOPER_N_TAU):0] syst_cnt_t;

	typedef enum logic [1:0] {
		SYST_NONE  = 2'd0,
		SYST_EDGE  = 2'd1,
		SYST_OUTER = 2'd2,
		SYST_INNER = 2'd3
	} syst_type_t;

endpackage

`default_nettype wire

// ==== src/looper_config.svh ====
/*
 * Accumulation block looper configuration
 * Offset width, grid dimensions, id table sizes and systolic array side
 */
`ifndef LOOPER_CONFIG_SVH
`define LOOPER_CONFIG_SVH

// Width of one offset word
`define LOOPER_WORK_BW 16

// Number of grid dimensions, dimension 0 innermost
`define LOOPER_VDIM 2

// Config and instruction table sizes
`define LOOPER_N_ICFG 8
`define LOOPER_N_OCFG 4
`define LOOPER_N_INST 16

// Side of the systolic array
`define LOOPER_N_TAU 4

`endif
